// File: Makefile
TOP := tb_rv_core_apb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f rv_core_apb.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

lint:
	verilator --lint-only --timing -f rv_core_apb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter int half_period = 10,
	parameter int reset_cycles = 16
	) (
	output logic clk,
	output logic reset
	);

	// free running clock, 20 ns period by default
	initial
	begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// synchronous reset, released just after an edge
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

// File: dv/tb_rv_core_apb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core_apb;

	localparam int max_polls = 200;
	localparam int num_tests = 6;
	localparam int apb_cycles = 3;
	// worst case polling for every test plus room for loads and reads
	localparam longint watchdog_ns = num_tests * max_polls * apb_cycles * 20 + 50000;

	logic clk;
	logic reset;
	rv_pkg::apb_req_t apb_req;
	rv_pkg::apb_rsp_t apb_rsp;

	// program words waiting to be loaded at address 0
	rv_pkg::inst_t prog[$];
	int test_errs;
	int pass_count;
	int fail_count;

	clock_gen clock_gen_i (
		.clk(clk),
		.reset(reset)
	);

	rv_core_apb dut_i (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	// instruction encoders for the rv32i formats
	function automatic rv_pkg::inst_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_R};
	endfunction

	function automatic rv_pkg::inst_t i_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// sw only
	function automatic rv_pkg::inst_t s_type(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic rv_pkg::inst_t b_type(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	function automatic rv_pkg::inst_t u_type(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rv_pkg::inst_t j_type(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
	endfunction

	// jal x0, 0 stops the core
	function automatic rv_pkg::inst_t self_jump();
		return j_type(21'd0, 0);
	endfunction

	// one apb transfer with setup and access phases, then the bus is released
	task automatic apb_access(input logic write, input rv_pkg::apb_addr_t addr,
		input rv_pkg::xlen_t wdata, output rv_pkg::xlen_t rdata, output logic err);
		@(posedge clk);
		#2;
		apb_req.paddr = addr;
		apb_req.pwrite = write;
		apb_req.pwdata = wdata;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		// response is stable mid cycle
		@(negedge clk);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		if (apb_rsp.pready !== 1'b1)
		begin
			$display("error at %0t: pready low in the access phase to %h", $time, addr);
			test_errs++;
		end
		@(posedge clk);
		#2;
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(input rv_pkg::apb_addr_t addr, input rv_pkg::xlen_t data,
		output logic err);
		rv_pkg::xlen_t unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input rv_pkg::apb_addr_t addr, output rv_pkg::xlen_t data,
		output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	task automatic check_reg(input int idx, input rv_pkg::xlen_t expected);
		rv_pkg::xlen_t got;
		logic err;
		apb_read(rv_pkg::apb_addr_t'(`RV_APB_REG_BASE + 4 * idx), got, err);
		if (err || got !== expected)
		begin
			$display("error at %0t: x%0d read %h, expected %h", $time, idx, got, expected);
			test_errs++;
		end
	endtask

	task automatic load_program();
		logic err;
		foreach (prog[i])
		begin
			apb_write(rv_pkg::apb_addr_t'(`RV_APB_IMEM_BASE + 4 * i), prog[i], err);
			if (err)
			begin
				$display("the core refused the program load of word %0d", i);
				test_errs++;
			end
		end
		prog.delete();
	endtask

	// set run, then poll control until the halted bit shows up
	task automatic start_and_wait(output logic halted);
		rv_pkg::xlen_t status;
		logic err;
		int polls;
		halted = 1'b0;
		polls = 0;
		apb_write(`RV_APB_CTRL_ADDR, 1, err);
		while (!halted && polls < max_polls)
		begin
			apb_read(`RV_APB_CTRL_ADDR, status, err);
			halted = status[1];
			polls++;
		end
		if (!halted)
		begin
			$display("the program did not halt within %0d control polls", max_polls);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			pass_count++;
			$display("test %s: passed", name);
		end
		else
		begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic test_register_map();
		rv_pkg::xlen_t word;
		rv_pkg::xlen_t got;
		logic err;
		// idle after reset means neither running nor halted
		apb_read(`RV_APB_CTRL_ADDR, got, err);
		if (got !== '0 || err)
		begin
			$display("error at %0t: control read %h after reset, expected idle", $time, got);
			test_errs++;
		end
		word = $urandom();
		apb_write(`RV_APB_IMEM_BASE + 12'h010, word, err);
		apb_read(`RV_APB_IMEM_BASE + 12'h010, got, err);
		if (got !== word || err)
		begin
			$display("error at %0t: imem word read %h, expected %h", $time, got, word);
			test_errs++;
		end
		apb_read(12'h300, got, err);
		if (err !== 1'b1)
		begin
			$display("error at %0t: unmapped read gave no pslverr", $time);
			test_errs++;
		end
		apb_write(`RV_APB_REG_BASE + 12'h004, word, err);
		if (err !== 1'b1)
		begin
			$display("error at %0t: register window write gave no pslverr", $time);
			test_errs++;
		end
		finish_test("register map");
	endtask

	task automatic test_alu();
		rv_pkg::xlen_t r;
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		logic halted;
		r = $urandom();
		imm_a = r[11:0];
		imm_b = r[27:16];
		a = {{20{imm_a[11]}}, imm_a};
		b = {{20{imm_b[11]}}, imm_b};
		prog.push_back(i_type(imm_a, 0, 3'b000, 1, `RV_OP_IMM));
		prog.push_back(i_type(imm_b, 0, 3'b000, 2, `RV_OP_IMM));
		prog.push_back(r_type(7'h00, 2, 1, 3'b000, 3));
		prog.push_back(r_type(7'h20, 2, 1, 3'b000, 4));
		prog.push_back(r_type(7'h00, 2, 1, 3'b010, 5));
		prog.push_back(r_type(7'h00, 2, 1, 3'b011, 6));
		prog.push_back(r_type(7'h00, 2, 1, 3'b100, 7));
		prog.push_back(r_type(7'h00, 2, 1, 3'b110, 8));
		prog.push_back(r_type(7'h00, 2, 1, 3'b111, 9));
		prog.push_back(r_type(7'h00, 2, 1, 3'b001, 10));
		prog.push_back(r_type(7'h00, 2, 1, 3'b101, 11));
		prog.push_back(r_type(7'h20, 2, 1, 3'b101, 12));
		prog.push_back(self_jump());
		load_program();
		start_and_wait(halted);
		check_reg(1, a);
		check_reg(2, b);
		check_reg(3, a + b);
		check_reg(4, a - b);
		// signed compare decided by the sign bits when they differ
		check_reg(5, {31'b0, (a[31] != b[31]) ? a[31] : (a < b)});
		check_reg(6, rv_pkg::xlen_t'(a < b));
		check_reg(7, a ^ b);
		check_reg(8, a | b);
		check_reg(9, a & b);
		// shift amount is the low five bits of rs2
		check_reg(10, a << b[4:0]);
		check_reg(11, a >> b[4:0]);
		// sign bit fills the vacated upper bits
		check_reg(12, (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffffffff >> b[4:0])));
		finish_test("alu program");
	endtask

	task automatic test_upper_imm();
		rv_pkg::xlen_t r;
		logic [19:0] u1;
		logic [19:0] u2;
		logic halted;
		r = $urandom();
		u1 = r[19:0];
		r = $urandom();
		u2 = r[19:0];
		prog.push_back(u_type(u1, 13, `RV_OP_LUI));
		// auipc sits at pc 4
		prog.push_back(u_type(u2, 14, `RV_OP_AUIPC));
		prog.push_back(self_jump());
		load_program();
		start_and_wait(halted);
		check_reg(13, {u1, 12'b0});
		check_reg(14, {u2, 12'b0} + 32'd4);
		finish_test("upper immediates");
	endtask

	task automatic test_control_flow();
		int unsigned limit;
		logic halted;
		limit = 2 + ($urandom() % 6);
		prog.push_back(i_type(12'd0, 0, 3'b000, 1, `RV_OP_IMM));
		prog.push_back(i_type(12'(limit), 0, 3'b000, 2, `RV_OP_IMM));
		// at pc 8 count x1 up to the limit with bne
		prog.push_back(i_type(12'd1, 1, 3'b000, 1, `RV_OP_IMM));
		prog.push_back(b_type(13'(-4), 2, 1, 3'b001));
		prog.push_back(i_type(12'd0, 0, 3'b000, 3, `RV_OP_IMM));
		// at pc 20 the same count in x3 with blt
		prog.push_back(i_type(12'd1, 3, 3'b000, 3, `RV_OP_IMM));
		prog.push_back(b_type(13'(-4), 2, 3, 3'b100));
		prog.push_back(i_type(12'd77, 0, 3'b000, 4, `RV_OP_IMM));
		// taken beq at pc 32 skips the write of 99
		prog.push_back(b_type(13'd8, 2, 1, 3'b000));
		prog.push_back(i_type(12'd99, 0, 3'b000, 4, `RV_OP_IMM));
		// jal at pc 40 links 44
		prog.push_back(j_type(21'd8, 5));
		prog.push_back(i_type(12'd1, 0, 3'b000, 4, `RV_OP_IMM));
		prog.push_back(i_type(12'd60, 0, 3'b000, 7, `RV_OP_IMM));
		// jalr at pc 52 jumps to 60 and links 56
		prog.push_back(i_type(12'd0, 7, 3'b000, 6, `RV_OP_JALR));
		prog.push_back(i_type(12'd2, 0, 3'b000, 4, `RV_OP_IMM));
		prog.push_back(self_jump());
		load_program();
		start_and_wait(halted);
		check_reg(1, limit);
		check_reg(3, limit);
		check_reg(4, 32'd77);
		check_reg(5, 32'd44);
		check_reg(6, 32'd56);
		check_reg(7, 32'd60);
		finish_test("control flow");
	endtask

	task automatic test_memory();
		rv_pkg::xlen_t d1;
		rv_pkg::xlen_t d2;
		rv_pkg::xlen_t t1;
		rv_pkg::xlen_t t2;
		int unsigned k1;
		int unsigned k2;
		logic halted;
		d1 = $urandom();
		d2 = $urandom();
		// two distinct word offsets
		k1 = $urandom() % 64;
		k2 = (k1 + 1 + ($urandom() % 63)) % 64;
		// lui takes the rounded upper part, addi adds the signed low 12 bits
		t1 = d1 + 32'h800;
		t2 = d2 + 32'h800;
		prog.push_back(u_type(t1[31:12], 15, `RV_OP_LUI));
		prog.push_back(i_type(d1[11:0], 15, 3'b000, 15, `RV_OP_IMM));
		prog.push_back(u_type(t2[31:12], 16, `RV_OP_LUI));
		prog.push_back(i_type(d2[11:0], 16, 3'b000, 16, `RV_OP_IMM));
		prog.push_back(s_type(12'(4 * k1), 15, 0));
		prog.push_back(s_type(12'(4 * k2), 16, 0));
		prog.push_back(i_type(12'(4 * k1), 0, 3'b010, 17, `RV_OP_LOAD));
		prog.push_back(i_type(12'(4 * k2), 0, 3'b010, 18, `RV_OP_LOAD));
		// load into x0 is dropped
		prog.push_back(i_type(12'(4 * k1), 0, 3'b010, 0, `RV_OP_LOAD));
		prog.push_back(self_jump());
		load_program();
		start_and_wait(halted);
		check_reg(17, d1);
		check_reg(18, d2);
		check_reg(0, '0);
		finish_test("memory");
	endtask

	task automatic test_restart();
		rv_pkg::xlen_t r;
		rv_pkg::xlen_t v;
		rv_pkg::xlen_t status;
		logic [11:0] imm;
		logic err;
		logic halted;
		r = $urandom();
		imm = r[11:0];
		v = {{20{imm[11]}}, imm};
		prog.push_back(i_type(imm, 0, 3'b000, 20, `RV_OP_IMM));
		prog.push_back(r_type(7'h00, 20, 20, 3'b000, 21));
		// x22 counts how often the program ran from pc 0
		prog.push_back(i_type(12'd1, 22, 3'b000, 22, `RV_OP_IMM));
		prog.push_back(self_jump());
		load_program();
		start_and_wait(halted);
		apb_read(`RV_APB_CTRL_ADDR, status, err);
		if (status !== 32'd2)
		begin
			$display("error at %0t: control read %h after halt, expected 2", $time, status);
			test_errs++;
		end
		check_reg(20, v);
		check_reg(21, v + v);
		check_reg(22, 32'd1);
		// rerun the same program without reloading
		start_and_wait(halted);
		check_reg(20, v);
		check_reg(21, v + v);
		check_reg(22, 32'd2);
		finish_test("halt and restart");
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(70193));
		apb_req = '0;
		test_errs = 0;
		pass_count = 0;
		fail_count = 0;
		wait (reset === 1'b0);
		test_register_map();
		test_alu();
		test_upper_imm();
		test_control_flow();
		test_memory();
		test_restart();
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: rv_core_apb.f
+incdir+src
src/rv_pkg.sv
src/instruction_decode.sv
src/execute_stage.sv
src/result_stage.sv
src/program_control.sv
src/rv_core_apb.sv
dv/clock_gen.sv
dv/tb_rv_core_apb.sv

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_stage (
	input rv_pkg::decode_ctrl_t ctrl,
	input rv_pkg::xlen_t pc,
	input rv_pkg::xlen_t rs1_data,
	input rv_pkg::xlen_t rs2_data,
	output rv_pkg::exec_result_t ex
	);

	rv_pkg::xlen_t op1;
	rv_pkg::xlen_t op2;
	rv_pkg::xlen_t alu_y;
	rv_pkg::xlen_t target_sum;
	rv_pkg::xlen_t pc_plus_four;
	logic [4:0] shamt;
	logic zero;
	logic taken;

	// operand 1: register, pc for auipc, zero for lui
	always_comb
		case (ctrl.op1_src)
			2'd0: op1 = rs1_data;
			2'd1: op1 = pc;
			default: op1 = '0;
		endcase

	assign op2 = ctrl.op2_src ? ctrl.immediate : rs2_data;
	// only the low five bits shift
	assign shamt = op2[4:0];

	always_comb
		case (ctrl.alu_op)
			3'b000: alu_y = ctrl.sign ? (op1 - op2) : (op1 + op2);
			3'b001: alu_y = op1 << shamt;
			3'b010: alu_y = {{(`RV_XLEN-1){1'b0}}, ($signed(op1) < $signed(op2))};
			3'b011: alu_y = {{(`RV_XLEN-1){1'b0}}, (op1 < op2)};
			3'b100: alu_y = op1 ^ op2;
			3'b101: alu_y = ctrl.sign ? rv_pkg::xlen_t'($signed(op1) >>> shamt) : (op1 >> shamt);
			3'b110: alu_y = op1 | op2;
			default: alu_y = op1 & op2;
		endcase

	assign zero = (alu_y == '0);

	// jumps always, branches when the zero flag matches the wanted one
	assign taken = ctrl.jump || (ctrl.branch && (ctrl.branch_if_zero == zero));

	// jalr adds to rs1, everything else adds to pc
	assign target_sum = (ctrl.branch_base ? rs1_data : pc) + ctrl.immediate;
	assign pc_plus_four = pc + rv_pkg::xlen_t'(4);

	assign ex.alu_result = alu_y;
	assign ex.pc_plus_four = pc_plus_four;
	// jalr clears bit 0 of the sum
	assign ex.next_pc = taken
		? {target_sum[`RV_XLEN-1:1], target_sum[0] & ~ctrl.branch_base}
		: pc_plus_four;

	// catches a jalr through a register that is not word aligned
	always_comb
	begin
		assert ($isunknown(ex.next_pc) || (ex.next_pc[1:0] == 2'b00))
		else $error("next_pc %h not word aligned at pc %h", ex.next_pc, pc);
	end

endmodule

// File: src/instruction_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module instruction_decode (
	input rv_pkg::inst_t instruction,
	output rv_pkg::decode_ctrl_t ctrl
	);

	logic [6:0] opcode;
	logic [2:0] funct3;
	rv_pkg::xlen_t i_imm;
	rv_pkg::xlen_t s_imm;
	rv_pkg::xlen_t b_imm;
	rv_pkg::xlen_t j_imm;
	rv_pkg::xlen_t u_imm;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];

	// immediates, all sign extended from bit 31
	assign i_imm = {{(`RV_XLEN-12){instruction[31]}}, instruction[31:20]};
	assign s_imm = {{(`RV_XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign b_imm = {
		{(`RV_XLEN-13){instruction[31]}},
		instruction[31],
		instruction[7],
		instruction[30:25],
		instruction[11:8],
		1'b0
	};
	assign j_imm = {
		{(`RV_XLEN-21){instruction[31]}},
		instruction[31],
		instruction[19:12],
		instruction[20],
		instruction[30:21],
		1'b0
	};
	// upper immediate, low 12 bits zero
	assign u_imm = {instruction[31:12], 12'b0};

	always_comb
	begin
		// everything off unless the opcode turns it on
		ctrl = '0;
		// register fields sit at fixed bits in every format
		ctrl.rs1 = instruction[19:15];
		ctrl.rs2 = instruction[24:20];
		ctrl.rd = instruction[11:7];

		case (opcode)
			`RV_OP_R:
			begin
				ctrl.alu_op = funct3;
				// sub and sra
				ctrl.sign = instruction[30];
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_IMM:
			begin
				ctrl.immediate = i_imm;
				ctrl.op2_src = 1'b1;
				ctrl.alu_op = funct3;
				// bit 30 only selects srai, for addi it is immediate data
				ctrl.sign = (funct3 == 3'b101) && instruction[30];
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_LOAD:
			begin
				// address = rs1 + imm through the adder
				ctrl.immediate = i_imm;
				ctrl.op2_src = 1'b1;
				ctrl.rd_select = 2'd1;
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_STORE:
			begin
				ctrl.immediate = s_imm;
				ctrl.op2_src = 1'b1;
				ctrl.mem_write_en = 1'b1;
			end
			`RV_OP_BRANCH:
			begin
				ctrl.immediate = b_imm;
				// branch if (branch_if_zero == zero) on the alu result
				case (funct3)
					3'b000, 3'b001:
					begin
						// beq, bne: subtract and test zero
						ctrl.alu_op = 3'b000;
						ctrl.sign = 1'b1;
						ctrl.branch = 1'b1;
					end
					3'b100, 3'b101:
					begin
						// blt, bge via slt
						ctrl.alu_op = 3'b010;
						ctrl.branch = 1'b1;
					end
					3'b110, 3'b111:
					begin
						// bltu, bgeu via sltu
						ctrl.alu_op = 3'b011;
						ctrl.branch = 1'b1;
					end
					default:
					begin
						// funct3 010 and 011 are not branches
						ctrl.branch = 1'b0;
					end
				endcase
				// beq, bge, bgeu take the branch on a zero result
				ctrl.branch_if_zero = ctrl.branch
					&& ((funct3 == 3'b000) || (funct3 == 3'b101) || (funct3 == 3'b111));
			end
			`RV_OP_JAL:
			begin
				ctrl.immediate = j_imm;
				ctrl.jump = 1'b1;
				ctrl.rd_select = 2'd2;
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_JALR:
			begin
				ctrl.immediate = i_imm;
				ctrl.op2_src = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.branch_base = 1'b1;
				ctrl.rd_select = 2'd2;
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_LUI:
			begin
				// zero + imm
				ctrl.immediate = u_imm;
				ctrl.op1_src = 2'd2;
				ctrl.op2_src = 1'b1;
				ctrl.rf_write_en = 1'b1;
			end
			`RV_OP_AUIPC:
			begin
				// pc + imm
				ctrl.immediate = u_imm;
				ctrl.op1_src = 2'd1;
				ctrl.op2_src = 1'b1;
				ctrl.rf_write_en = 1'b1;
			end
			default:
			begin
				// illegal opcode runs as a no-op
				ctrl.rf_write_en = 1'b0;
			end
		endcase
	end

endmodule

// File: src/program_control.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module program_control (
	input logic clk,
	input logic reset,
	input rv_pkg::apb_req_t apb_req,
	output rv_pkg::apb_rsp_t apb_rsp,
	input rv_pkg::xlen_t next_pc,
	output rv_pkg::xlen_t pc,
	output rv_pkg::inst_t instruction,
	output logic commit,
	output rv_pkg::reg_idx_t dbg_idx,
	input rv_pkg::xlen_t dbg_data
	);

	localparam int imem_aw = $clog2(`RV_IMEM_WORDS);

	rv_pkg::core_state_t state;
	rv_pkg::inst_t imem [`RV_IMEM_WORDS];
	rv_pkg::apb_addr_t imem_off;
	rv_pkg::apb_addr_t reg_off;
	logic access;
	logic imem_hit;
	logic ctrl_hit;
	logic reg_hit;
	logic wr_err;
	logic ctrl_wr;

	// access phase, no wait states
	assign access = apb_req.psel && apb_req.penable;

	// offsets wrap below the base, so one compare per window is enough
	assign imem_off = apb_req.paddr - rv_pkg::apb_addr_t'(`RV_APB_IMEM_BASE);
	assign reg_off = apb_req.paddr - rv_pkg::apb_addr_t'(`RV_APB_REG_BASE);
	assign imem_hit = imem_off < rv_pkg::apb_addr_t'(4 * `RV_IMEM_WORDS);
	assign reg_hit = reg_off < rv_pkg::apb_addr_t'(4 * 32);
	assign ctrl_hit = apb_req.paddr == rv_pkg::apb_addr_t'(`RV_APB_CTRL_ADDR);
	assign dbg_idx = reg_off[6:2];

	// register window is read only, imem is locked while running
	assign wr_err = apb_req.pwrite
		&& (reg_hit || (imem_hit && (state == rv_pkg::state_run)));
	assign ctrl_wr = access && apb_req.pwrite && ctrl_hit;

	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access && (!(imem_hit || ctrl_hit || reg_hit) || wr_err);

	always_comb
		if (imem_hit)
			apb_rsp.prdata = imem[imem_off[imem_aw+1:2]];
		else if (ctrl_hit)
			apb_rsp.prdata = {{(`RV_XLEN-2){1'b0}},
				state == rv_pkg::state_halted, state == rv_pkg::state_run};
		else if (reg_hit)
			apb_rsp.prdata = dbg_data;
		else
			apb_rsp.prdata = '0;

	// host program load
	always_ff @(posedge clk)
		if (access && apb_req.pwrite && imem_hit && !wr_err)
			imem[imem_off[imem_aw+1:2]] <= apb_req.pwdata;

	assign commit = (state == rv_pkg::state_run);
	assign instruction = imem[pc[imem_aw+1:2]];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= rv_pkg::state_idle;
			pc <= '0;
		end
		else
		begin
			// one instruction per clock, a jump to self stops the core
			if (state == rv_pkg::state_run)
			begin
				pc <= next_pc;
				if (next_pc == pc)
					state <= rv_pkg::state_halted;
			end
			// host control write wins over the commit
			if (ctrl_wr)
			begin
				if (apb_req.pwdata[0])
				begin
					state <= rv_pkg::state_run;
					pc <= '0;
				end
				else
					state <= rv_pkg::state_idle;
			end
		end
	end

	// every access phase is preceded by exactly one setup phase
	assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
	else $error("apb access phase without setup phase");

endmodule

// File: src/result_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module result_stage (
	input logic clk,
	input logic reset,
	input logic commit,
	input rv_pkg::decode_ctrl_t ctrl,
	input rv_pkg::exec_result_t ex,
	output rv_pkg::xlen_t rs1_data,
	output rv_pkg::xlen_t rs2_data,
	input rv_pkg::reg_idx_t dbg_idx,
	output rv_pkg::xlen_t dbg_data
	);

	localparam int num_regs = 32;
	localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

	rv_pkg::xlen_t regs [num_regs];
	rv_pkg::xlen_t dmem [`RV_DMEM_WORDS];
	logic [dmem_aw-1:0] dmem_idx;
	rv_pkg::xlen_t load_data;
	rv_pkg::xlen_t wb_data;

	// x0 always reads as zero on every port
	assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
	assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];
	assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];

	// word index from the byte address with the upper bits wrapping
	assign dmem_idx = ex.alu_result[dmem_aw+1:2];
	assign load_data = dmem[dmem_idx];

	// writeback select
	always_comb
		case (ctrl.rd_select)
			2'd0: wb_data = ex.alu_result;
			2'd1: wb_data = load_data;
			default: wb_data = ex.pc_plus_four;
		endcase

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
			for (int j = 0; j < `RV_DMEM_WORDS; j++)
				dmem[j] <= '0;
		end
		else if (commit)
		begin
			// store data is rs2 and the address comes from the alu adder
			if (ctrl.mem_write_en)
				dmem[dmem_idx] <= rs2_data;
			if (ctrl.rf_write_en && (ctrl.rd != '0))
				regs[ctrl.rd] <= wb_data;
		end
	end

	// word accesses only, so a committed load or store has its low address bits clear
	assert property (@(posedge clk) disable iff (reset)
		commit && (ctrl.mem_write_en || (ctrl.rd_select == 2'd1))
		|-> (ex.alu_result[1:0] == 2'b00))
	else $error("data memory address %h not word aligned", ex.alu_result);

endmodule

// File: src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width, only 32 is supported
`define RV_XLEN 32

// memory depths in words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64

// base opcodes, instruction bits 6:0
`define RV_OP_R 7'b0110011
`define RV_OP_IMM 7'b0010011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_JALR 7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_STORE 7'b0100011
`define RV_OP_JAL 7'b1101111
`define RV_OP_LUI 7'b0110111
`define RV_OP_AUIPC 7'b0010111

// apb address map, byte addresses
`define RV_APB_AW 12
`define RV_APB_IMEM_BASE 12'h000
`define RV_APB_CTRL_ADDR 12'h100
`define RV_APB_REG_BASE 12'h200

`endif

// File: src/rv_core_apb.sv
`timescale 1ns/1ps

module rv_core_apb (
	input logic clk,
	input logic reset,
	input rv_pkg::apb_req_t apb_req,
	output rv_pkg::apb_rsp_t apb_rsp
	);

	rv_pkg::xlen_t pc;
	rv_pkg::inst_t instruction;
	logic commit;
	rv_pkg::decode_ctrl_t ctrl;
	rv_pkg::exec_result_t ex;
	rv_pkg::xlen_t rs1_data;
	rv_pkg::xlen_t rs2_data;
	rv_pkg::reg_idx_t dbg_idx;
	rv_pkg::xlen_t dbg_data;

	// fetch, apb slave and run control
	program_control program_control_i (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.next_pc(ex.next_pc),
		.pc(pc),
		.instruction(instruction),
		.commit(commit),
		.dbg_idx(dbg_idx),
		.dbg_data(dbg_data)
	);

	instruction_decode instruction_decode_i (
		.instruction(instruction),
		.ctrl(ctrl)
	);

	execute_stage execute_stage_i (
		.ctrl(ctrl),
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex(ex)
	);

	// register file and data memory, written on commit
	result_stage result_stage_i (
		.clk(clk),
		.reset(reset),
		.commit(commit),
		.ctrl(ctrl),
		.ex(ex),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.dbg_idx(dbg_idx),
		.dbg_data(dbg_data)
	);

endmodule

// File: src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;
	// same encoding as funct3
	typedef logic [2:0] alu_op_t;
	typedef logic [`RV_APB_AW-1:0] apb_addr_t;

	// decoder outputs, one field per control line of the datapath
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		xlen_t immediate;
		// 0 register, 1 pc, 2 zero
		logic [1:0] op1_src;
		// 0 register, 1 immediate
		logic op2_src;
		// 0 alu, 1 memory, 2 pc + 4
		logic [1:0] rd_select;
		alu_op_t alu_op;
		logic sign;
		logic branch;
		logic branch_if_zero;
		logic jump;
		// 0 pc, 1 rs1 for jalr
		logic branch_base;
		logic rf_write_en;
		logic mem_write_en;
	} decode_ctrl_t;

	typedef struct packed {
		xlen_t alu_result;
		xlen_t next_pc;
		xlen_t pc_plus_four;
	} exec_result_t;

	typedef struct packed {
		apb_addr_t paddr;
		logic psel;
		logic penable;
		logic pwrite;
		xlen_t pwdata;
	} apb_req_t;

	typedef struct packed {
		xlen_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		state_idle,
		state_run,
		state_halted
	} core_state_t;

endpackage
